// File: sources.f
+incdir+verilog
verilog/icache_pkg.sv
verilog/sdp_ram.sv
verilog/icache_tagv.sv
verilog/icache_lru.sv
verilog/icache_ctrl.sv
verilog/icache_top.sv
dv/icache_tb.sv

// File: Makefile
TOP := icache_tb
SIM := obj_dir/V$(TOP)

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --timescale 1ns/1ps -f sources.f --top-module $(TOP)

sim: $(SIM)
	./$(SIM)

$(SIM): sources.f verilog/*.sv verilog/*.svh dv/*.sv
	verilator --binary --timing --assert --timescale 1ns/1ps -f sources.f --top-module $(TOP)

clean:
	rm -rf obj_dir

// File: dv/icache_tb.sv
`timescale 1ns/1ps
`include "icache_defs.svh"

module icache_tb
    import icache_pkg::*;
;

    localparam int CLK_PERIOD   = 4;
    localparam int N_DIRECTED   = 12;
    localparam int N_RANDOM     = 100;
    localparam int N_REQ        = N_DIRECTED + N_RANDOM;
    // Reset plus the init walk
    localparam int INIT_CYC     = 2 + `ICACHE_SETS;
    localparam int WATCHDOG_CYC = N_REQ * 20 + INIT_CYC;

    typedef struct packed {
        logic        miss;
        mem_req_t    line;
        logic [31:0] word;
    } expect_t;

    logic         clk = 1'b0;
    logic         rst_n;
    logic         req_valid;
    logic         req_ready;
    icache_req_t  req;
    logic         resp_valid;
    logic         resp_ready = 1'b0;
    icache_resp_t resp;
    logic         mem_req_valid;
    logic         mem_req_ready = 1'b0;
    mem_req_t     mem_req;
    logic         mem_resp_valid = 1'b0;
    mem_resp_t    mem_resp = '0;
    logic         flush;

    integer       seed = 32'he9d78170;
    expect_t      exp_q [$];
    int           mem_cnt = 0;
    logic         held = 1'b0;
    logic [31:0]  held_word = '0;
    logic         mem_taken = 1'b0;
    mem_req_t     mem_line = '0;
    int           mem_delay = 0;

    // Address pool of three tags over three sets
    icache_tag_t  tag_pool [3] = '{24'h0001f0, 24'h0002e1, 24'h0003d2};
    logic [3:0]   idx_pool [3] = '{4'd3, 4'd5, 4'd9};

    // Reference model of tags, valid bits and LRU
    icache_tag_t  m_tag   [`ICACHE_SETS][`ICACHE_WAYS];
    logic         m_valid [`ICACHE_SETS][`ICACHE_WAYS];
    logic         m_lru   [`ICACHE_SETS];

    icache_top u_icache_top (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic logic [31:0] mem_word(input mem_req_t line, input logic [1:0] w);
        return ((32'(line) << 2) + 32'(w)) ^ 32'h5a5a0000;
    endfunction

    // Returns one on a miss, then updates the set
    function automatic logic model_access(input icache_tag_t t, input logic [3:0] i);
        logic found;
        logic way;
        found = 1'b0;
        way   = m_lru[i];
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            if (m_valid[i][w] && m_tag[i][w] == t) begin
                found = 1'b1;
                way   = 1'(w);
            end
        end
        if (!found) begin
            m_valid[i][way] = 1'b1;
            m_tag[i][way]   = t;
        end
        m_lru[i] = ~way;
        return !found;
    endfunction

    task automatic stop_fail(input string why);
        $display("%s", why);
        $display("sim failed");
        $fatal(1, "run stopped on error");
    endtask

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        if (got !== exp) begin
            stop_fail($sformatf("Fail %s: got %h, expected %h", name, got, exp));
        end
    endtask

    //////////////////////////////
    // Stimulus tasks
    //////////////////////////////

    // Starts and ends on a falling edge
    task automatic fetch(input icache_tag_t t, input logic [3:0] i, input logic [1:0] w,
                         input int want_miss);
        expect_t e;
        @(posedge clk);
        #1;
        req_valid = 1'b1;
        req.addr  = '{tag: t, index: i, offset: {w, 2'b00}};
        @(negedge clk);
        while (!req_ready) begin
            @(negedge clk);
        end
        e.miss = model_access(t, i);
        e.line = '{tag: t, index: i};
        e.word = mem_word(e.line, w);
        exp_q.push_back(e);
        if (want_miss >= 0) begin
            check_val("model miss", 32'(e.miss), 32'(want_miss));
        end
        @(posedge clk);
        #1;
        req_valid = 1'b0;
        @(negedge clk);
    endtask

    // Only pulsed with no fetch in flight
    task automatic pulse_flush();
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        flush = 1'b1;
        for (int s = 0; s < `ICACHE_SETS; s++) begin
            m_valid[s][0] = 1'b0;
            m_valid[s][1] = 1'b0;
        end
        @(posedge clk);
        #1;
        flush = 1'b0;
        @(negedge clk);
    endtask

    initial begin
        rst_n     = 1'b0;
        req_valid = 1'b0;
        req       = '0;
        flush     = 1'b0;
        for (int s = 0; s < `ICACHE_SETS; s++) begin
            m_valid[s][0] = 1'b0;
            m_valid[s][1] = 1'b0;
            m_tag[s][0]   = '0;
            m_tag[s][1]   = '0;
            m_lru[s]      = 1'b0;
        end
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(negedge clk);
        fetch(24'h000010, 4'd3, 2'd1, 1);
        fetch(24'h000010, 4'd3, 2'd2, 0);
        // Three lines into set 5
        fetch(24'h0000a1, 4'd5, 2'd0, 1);
        fetch(24'h0000b2, 4'd5, 2'd3, 1);
        fetch(24'h0000a1, 4'd5, 2'd1, 0);
        fetch(24'h0000c3, 4'd5, 2'd2, 1);
        fetch(24'h0000a1, 4'd5, 2'd2, 0);
        fetch(24'h0000b2, 4'd5, 2'd0, 1);
        pulse_flush();
        fetch(24'h000010, 4'd3, 2'd0, 1);
        fetch(24'h0000a1, 4'd5, 2'd1, 1);
        fetch(24'h0000b2, 4'd5, 2'd3, 1);
        fetch(24'h000010, 4'd3, 2'd0, 0);
        for (int n = 0; n < N_RANDOM; n++) begin
            if (n % 25 == 24) begin
                pulse_flush();
            end
            fetch(tag_pool[rand_below(3)], idx_pool[rand_below(3)], 2'(rand_below(4)), -1);
            repeat (rand_below(2)) @(negedge clk);
        end
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        // A few quiet cycles with no fetch outstanding
        repeat (4) @(negedge clk);
        if (resp_valid || mem_req_valid || !req_ready) begin
            stop_fail("the cache did not return to idle after the last response");
        end else begin
            $display("sim passed");
            $finish;
        end
    end

    //////////////////////////////
    // Memory and fetch-side ready
    //////////////////////////////

    always begin
        @(negedge clk);
        mem_taken = mem_req_valid && mem_req_ready;
        if (mem_taken) begin
            mem_line = mem_req;
        end
        @(posedge clk);
        #1;
        resp_ready     = (rand_below(4) != 0);
        mem_req_ready  = (rand_below(2) == 0);
        mem_resp_valid = 1'b0;
        if (mem_taken) begin
            mem_delay = 1 + rand_below(4);
        end else if (mem_delay > 0) begin
            mem_delay--;
            if (mem_delay == 0) begin
                mem_resp_valid = 1'b1;
                for (int w = 0; w < `ICACHE_WORDS; w++) begin
                    mem_resp.line[w] = mem_word(mem_line, 2'(w));
                end
            end
        end
    end

    // Handshakes complete on the rising edge after this sample
    always @(negedge clk) begin : compare
        expect_t e;
        if (rst_n) begin
            if (held) begin
                check_val("resp_valid", 32'(resp_valid), 32'd1);
                check_val("resp", resp.data, held_word);
            end
            held      = resp_valid && !resp_ready;
            held_word = resp.data;
            if (req_valid && req_ready) begin
                mem_cnt = 0;
            end
            if (mem_req_valid && mem_req_ready) begin
                if (exp_q.size() == 0) begin
                    stop_fail("memory request seen with no fetch outstanding");
                end
                check_val("mem_req", 32'(mem_req), 32'(exp_q[0].line));
                mem_cnt++;
            end
            if (resp_valid && resp_ready) begin
                if (exp_q.size() == 0) begin
                    stop_fail("response seen with no fetch outstanding");
                end
                e = exp_q.pop_front();
                check_val("resp", resp.data, e.word);
                check_val("mem_req count", mem_cnt, 32'(e.miss));
            end
        end
    end

    initial begin
        #(WATCHDOG_CYC * CLK_PERIOD);
        stop_fail("timeout, the fetch sequence did not complete in time");
    end

endmodule

// File: verilog/icache_top.sv
`timescale 1ns/1ps
`include "icache_defs.svh"

module icache_top
    import icache_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  logic         req_valid,
    output logic         req_ready,
    input  icache_req_t  req,
    output logic         resp_valid,
    input  logic         resp_ready,
    output icache_resp_t resp,
    output logic         mem_req_valid,
    input  logic         mem_req_ready,
    output mem_req_t     mem_req,
    input  logic         mem_resp_valid,
    input  mem_resp_t    mem_resp,
    input  logic         flush
);

    logic [`ICACHE_INDEX_W-1:0] tag_raddr;
    logic [`ICACHE_INDEX_W-1:0] data_raddr;
    logic [`ICACHE_INDEX_W-1:0] lru_index;
    icache_tag_t                cmp_tag;
    tagv_wr_t                   tagv_wr;
    logic [`ICACHE_WAYS-1:0]    hit;
    logic [`ICACHE_WAYS-1:0]    data_we;
    logic                       lru_touch;
    logic                       lru_touch_way;
    logic                       victim;
    icache_line_t               line_wdata;
    icache_line_t               line_rdata0;
    icache_line_t               line_rdata1;

    icache_ctrl u_ctrl (.*);

    icache_tagv u_tagv (
        .clk     (clk),
        .rst_n   (rst_n),
        .raddr   (tag_raddr),
        .cmp_tag (cmp_tag),
        .wr      (tagv_wr),
        .flush   (flush),
        .hit     (hit)
    );

    icache_lru u_lru (
        .clk       (clk),
        .rst_n     (rst_n),
        .index     (lru_index),
        .touch     (lru_touch),
        .touch_way (lru_touch_way),
        .victim    (victim)
    );

    // Line storage shares the write index of the tag command
    sdp_ram #(.entry_t(icache_line_t), .ADDR_W(`ICACHE_INDEX_W)) u_data_way0 (
        .clk   (clk),
        .we    (data_we[0]),
        .waddr (tagv_wr.index),
        .wdata (line_wdata),
        .raddr (data_raddr),
        .rdata (line_rdata0)
    );

    sdp_ram #(.entry_t(icache_line_t), .ADDR_W(`ICACHE_INDEX_W)) u_data_way1 (
        .clk   (clk),
        .we    (data_we[1]),
        .waddr (tagv_wr.index),
        .wdata (line_wdata),
        .raddr (data_raddr),
        .rdata (line_rdata1)
    );

endmodule

// File: verilog/icache_ctrl.sv
`timescale 1ns/1ps
`include "icache_defs.svh"

module icache_ctrl
    import icache_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       req_valid,
    output logic                       req_ready,
    input  icache_req_t                req,
    output logic                       resp_valid,
    input  logic                       resp_ready,
    output icache_resp_t               resp,
    output logic                       mem_req_valid,
    input  logic                       mem_req_ready,
    output mem_req_t                   mem_req,
    input  logic                       mem_resp_valid,
    input  mem_resp_t                  mem_resp,
    input  logic                       flush,
    output logic [`ICACHE_INDEX_W-1:0] tag_raddr,
    output icache_tag_t                cmp_tag,
    output tagv_wr_t                   tagv_wr,
    input  logic [`ICACHE_WAYS-1:0]    hit,
    output logic [`ICACHE_INDEX_W-1:0] lru_index,
    output logic                       lru_touch,
    output logic                       lru_touch_way,
    input  logic                       victim,
    output logic [`ICACHE_INDEX_W-1:0] data_raddr,
    output logic [`ICACHE_WAYS-1:0]    data_we,
    output icache_line_t               line_wdata,
    input  icache_line_t               line_rdata0,
    input  icache_line_t               line_rdata1
);

    localparam int WSEL_W = $clog2(`ICACHE_WORDS);

    typedef enum logic [2:0] {
        INIT,
        IDLE,
        LOOKUP,
        MISS,
        REFILL,
        RESP
    } state_t;

    state_t                     state;
    state_t                     state_d;
    logic [`ICACHE_INDEX_W-1:0] init_cnt;
    icache_addr_t               req_q;
    icache_resp_t               resp_q;
    icache_resp_t               resp_d;
    icache_line_t               hit_line;
    logic [WSEL_W-1:0]          wsel;

    ////////////////////////////////
    // State and request buffer
    ////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= INIT;
            init_cnt <= '0;
        end else begin
            state <= state_d;
            if (state == INIT) begin
                init_cnt <= init_cnt + 1'b1;
            end
        end
    end

    // Payload registers
    always_ff @(posedge clk) begin
        if (req_valid && req_ready) begin
            req_q <= req.addr;
        end
        if (state_d == RESP && state != RESP) begin
            resp_q <= resp_d;
        end
    end

    assign req_ready     = (state == IDLE) && !flush;
    assign resp_valid    = (state == RESP);
    assign resp          = resp_q;
    assign mem_req_valid = (state == MISS);
    assign mem_req       = '{tag: req_q.tag, index: req_q.index};

    // Read index goes straight to the RAMs on acceptance
    assign tag_raddr  = req.addr.index;
    assign data_raddr = req.addr.index;
    assign cmp_tag    = req_q.tag;
    assign lru_index  = req_q.index;
    assign line_wdata = mem_resp.line;

    assign wsel     = req_q.offset[`ICACHE_OFFSET_W-1 -: WSEL_W];
    assign hit_line = hit[1] ? line_rdata1 : line_rdata0;

    ////////////////////////////////
    // Next state and commands
    ////////////////////////////////

    always_comb begin
        state_d       = state;
        tagv_wr.index = (state == INIT) ? init_cnt : req_q.index;
        tagv_wr.tag   = req_q.tag;
        tagv_wr.we    = '0;
        tagv_wr.inval = '0;
        tagv_wr.init  = (state == INIT);
        data_we       = '0;
        lru_touch     = 1'b0;
        lru_touch_way = victim;
        resp_d.data   = mem_resp.line[wsel];
        case (state)
            INIT: begin
                if (init_cnt == `ICACHE_INDEX_W'(`ICACHE_SETS - 1)) begin
                    state_d = IDLE;
                end
            end
            IDLE: begin
                if (req_valid && req_ready) begin
                    state_d = LOOKUP;
                end
            end
            LOOKUP: begin
                if (|hit) begin
                    resp_d.data   = hit_line[wsel];
                    lru_touch     = 1'b1;
                    lru_touch_way = hit[1];
                    state_d       = RESP;
                end else begin
                    // Victim stays invalid until the refill lands
                    tagv_wr.inval[victim] = 1'b1;
                    state_d               = MISS;
                end
            end
            MISS: begin
                if (mem_req_ready) begin
                    state_d = REFILL;
                end
            end
            REFILL: begin
                if (mem_resp_valid) begin
                    tagv_wr.we[victim] = 1'b1;
                    data_we[victim]    = 1'b1;
                    lru_touch          = 1'b1;
                    state_d            = RESP;
                end
            end
            RESP: begin
                if (resp_ready) begin
                    state_d = IDLE;
                end
            end
            default: begin
                state_d = INIT;
            end
        endcase
    end

    a_resp_stable: assert property (@(posedge clk) disable iff (!rst_n)
        resp_valid && !resp_ready |=> resp_valid && $stable(resp));

    a_mem_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
        mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_req));

    // A line lives in at most one way
    a_hit_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        state == LOOKUP |-> !(&hit));

endmodule

// File: verilog/icache_lru.sv
`timescale 1ns/1ps
`include "icache_defs.svh"

module icache_lru #(
    parameter int WAY_W = $clog2(`ICACHE_WAYS)
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic [`ICACHE_INDEX_W-1:0] index,
    input  logic                       touch,
    input  logic [WAY_W-1:0]           touch_way,
    output logic [WAY_W-1:0]           victim
);

    // One bit per set naming the least recently used way
    logic [`ICACHE_SETS-1:0] lru_bits;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            lru_bits <= '0;
        end else if (touch) begin
            // The other way becomes the victim
            lru_bits[index] <= ~touch_way;
        end
    end

    assign victim = lru_bits[index];

endmodule

// File: verilog/icache_tagv.sv
`timescale 1ns/1ps
`include "icache_defs.svh"

module icache_tagv
    import icache_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic [`ICACHE_INDEX_W-1:0] raddr,
    input  icache_tag_t                cmp_tag,
    input  tagv_wr_t                   wr,
    input  logic                       flush,
    output logic [`ICACHE_WAYS-1:0]    hit
);

    logic [`ICACHE_WAYS-1:0][`ICACHE_SETS-1:0] valid;
    icache_tag_t                               tag_way0;
    icache_tag_t                               tag_way1;

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            valid <= '0;
        end else if (wr.init) begin
            valid[0][wr.index] <= 1'b0;
            valid[1][wr.index] <= 1'b0;
        end else begin
            for (int w = 0; w < `ICACHE_WAYS; w++) begin
                if (wr.inval[w]) begin
                    valid[w][wr.index] <= 1'b0;
                end else if (wr.we[w]) begin
                    valid[w][wr.index] <= 1'b1;
                end
            end
        end
    end

    // Init writes tag zero into both ways
    sdp_ram #(.entry_t(icache_tag_t), .ADDR_W(`ICACHE_INDEX_W)) u_tag_way0 (
        .clk   (clk),
        .we    (wr.we[0] | wr.init),
        .waddr (wr.index),
        .wdata (wr.init ? icache_tag_t'(0) : wr.tag),
        .raddr (raddr),
        .rdata (tag_way0)
    );

    sdp_ram #(.entry_t(icache_tag_t), .ADDR_W(`ICACHE_INDEX_W)) u_tag_way1 (
        .clk   (clk),
        .we    (wr.we[1] | wr.init),
        .waddr (wr.index),
        .wdata (wr.init ? icache_tag_t'(0) : wr.tag),
        .raddr (raddr),
        .rdata (tag_way1)
    );

    // wr.index holds the buffered request index during lookup
    assign hit[0] = (tag_way0 == cmp_tag) && valid[0][wr.index];
    assign hit[1] = (tag_way1 == cmp_tag) && valid[1][wr.index];

    a_we_inval_excl: assert property (@(posedge clk) disable iff (!rst_n)
        (wr.we & wr.inval) == '0);

endmodule

// File: verilog/sdp_ram.sv
`timescale 1ns/1ps

module sdp_ram #(
    parameter type entry_t = logic [31:0],
    parameter int  ADDR_W  = 4
) (
    input  logic              clk,
    input  logic              we,
    input  logic [ADDR_W-1:0] waddr,
    input  entry_t            wdata,
    input  logic [ADDR_W-1:0] raddr,
    output entry_t            rdata
);

    entry_t mem [2**ADDR_W];

    // Registered read that returns old data on a same-address write
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
        rdata <= mem[raddr];
    end

endmodule

// File: verilog/icache_pkg.sv
`include "icache_defs.svh"

package icache_pkg;

    typedef logic [`ICACHE_TAG_W-1:0] icache_tag_t;

    typedef struct packed {
        icache_tag_t                  tag;
        logic [`ICACHE_INDEX_W-1:0]   index;
        logic [`ICACHE_OFFSET_W-1:0]  offset;
    } icache_addr_t;

    // Word 0 sits in the low bits
    typedef logic [`ICACHE_WORDS-1:0][`ICACHE_WORD_W-1:0] icache_line_t;

    typedef struct packed {
        icache_addr_t addr;
    } icache_req_t;

    typedef struct packed {
        logic [`ICACHE_WORD_W-1:0] data;
    } icache_resp_t;

    // Line address made of tag and index
    typedef struct packed {
        icache_tag_t                tag;
        logic [`ICACHE_INDEX_W-1:0] index;
    } mem_req_t;

    typedef struct packed {
        icache_line_t line;
    } mem_resp_t;

    // Write command from the controller to the tag array
    typedef struct packed {
        logic [`ICACHE_INDEX_W-1:0] index;
        icache_tag_t                tag;
        logic [`ICACHE_WAYS-1:0]    we;
        logic [`ICACHE_WAYS-1:0]    inval;
        logic                       init;
    } tagv_wr_t;

endpackage

// File: verilog/icache_defs.svh
`ifndef ICACHE_DEFS_SVH
`define ICACHE_DEFS_SVH

// Address split of a fetch address
`define ICACHE_ADDR_W   32
`define ICACHE_WORD_W   32
`define ICACHE_OFFSET_W 4
`define ICACHE_INDEX_W  4
`define ICACHE_TAG_W    24

// Cache geometry
`define ICACHE_WORDS    4
`define ICACHE_WAYS     2
`define ICACHE_SETS     16

`endif
